//--- design/ex_alu.sv
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
    input  alu_op_e   alu_op_i,
    ex_operand_if.alu ops,
    output word_t     result_o,
    output logic      ov_exc_o
);

    word_t sum;
    word_t diff;
    logic  [4:0] sh_amt;
    logic  add_ov;
    logic  sub_ov;

    assign sum    = ops.src1 + ops.src2;
    assign diff   = ops.src1 - ops.src2;
    assign sh_amt = ops.src1[4:0];

    // same-sign operands giving a result of the other sign
    assign add_ov = (ops.src1[31] == ops.src2[31]) && (sum[31] != ops.src1[31]);
    assign sub_ov = (ops.src1[31] != ops.src2[31]) && (diff[31] != ops.src1[31]);

    always_comb begin
        case (alu_op_i)
            ALU_ADD, ALU_ADDU: result_o = sum;
            ALU_SUB, ALU_SUBU: result_o = diff;
            ALU_SLT:  result_o = {31'b0, $signed(ops.src1) < $signed(ops.src2)};
            ALU_SLTU: result_o = {31'b0, ops.src1 < ops.src2};
            ALU_AND:  result_o = ops.src1 & ops.src2;
            ALU_OR:   result_o = ops.src1 | ops.src2;
            ALU_XOR:  result_o = ops.src1 ^ ops.src2;
            ALU_NOR:  result_o = ~(ops.src1 | ops.src2);
            ALU_SLL:  result_o = ops.src2 << sh_amt;
            ALU_SRL:  result_o = ops.src2 >> sh_amt;
            ALU_SRA:  result_o = word_t'($signed(ops.src2) >>> sh_amt);
            ALU_LUI:  result_o = {ops.src2[15:0], 16'b0};
            default:  result_o = '0;
        endcase
    end

    // addu and subu never trap
    always_comb begin
        case (alu_op_i)
            ALU_ADD: ov_exc_o = add_ov;
            ALU_SUB: ov_exc_o = sub_ov;
            default: ov_exc_o = 1'b0;
        endcase
    end

endmodule

//--- design/ex_branch_check.sv
`timescale 1ns/1ps

module ex_branch_check import ex_pkg::*; (
    input  br_op_e       br_op_i,
    input  word_t        pc_i,
    input  word_t        inst_i,
    ex_operand_if.branch ops,
    input  logic         bp_taken_i,
    input  word_t        bp_target_i,
    output logic         redirect_o,
    output word_t        target_o
);

    word_t pc_plus4;
    word_t br_dest;
    word_t jmp_dest;
    word_t actual_target;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  rs_zero;
    logic  taken;
    logic  wrong_taken;
    logic  wrong_not_taken;

    assign pc_plus4 = pc_i + INST_STEP;
    assign br_dest  = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    assign jmp_dest = {pc_plus4[31:28], inst_i[25:0], 2'b00};

    assign rs_eq_rt = (ops.rs_value == ops.rt_value);
    assign rs_neg   = ops.rs_value[31];
    assign rs_zero  = (ops.rs_value == '0);

    always_comb begin
        taken         = 1'b0;
        actual_target = br_dest;
        case (br_op_i)
            BR_BEQ:  taken = rs_eq_rt;
            BR_BNE:  taken = !rs_eq_rt;
            BR_BGEZ: taken = !rs_neg;
            BR_BGTZ: taken = !rs_neg && !rs_zero;
            BR_BLEZ: taken = rs_neg || rs_zero;
            BR_BLTZ: taken = rs_neg;
            BR_J, BR_JAL: begin
                taken         = 1'b1;
                actual_target = jmp_dest;
            end
            BR_JR, BR_JALR: begin
                taken         = 1'b1;
                actual_target = ops.rs_value;
            end
            default: taken = 1'b0;
        endcase
    end

    // taken but missed or sent elsewhere, or predicted taken for nothing
    assign wrong_taken     = taken && (!bp_taken_i || (bp_target_i != actual_target));
    assign wrong_not_taken = bp_taken_i && !taken;

    assign redirect_o = wrong_taken || wrong_not_taken;
    assign target_o   = wrong_taken     ? actual_target :
                        wrong_not_taken ? pc_i + LINK_OFFSET : '0;

endmodule

//--- design/ex_mem_access.sv
`timescale 1ns/1ps

module ex_mem_access import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_i,
    input  mem_op_e   mem_op_i,
    input  word_t     addr_i,
    input  logic      ov_exc_i,
    ex_operand_if.mem ops,
    output logic      dmem_en_o,
    output logic      dmem_we_o,
    output byte_sel_t dmem_sel_o,
    output word_t     dmem_addr_o,
    output word_t     dmem_wdata_o,
    output logic      adel_o,
    output logic      ades_o
);

    logic  store_block;
    logic  any_exc;
    logic  half_misaligned;
    logic  word_misaligned;
    byte_sel_t byte_lane;
    byte_sel_t half_lane;

    assign byte_lane = byte_sel_t'(4'b0001 << addr_i[1:0]);
    assign half_lane = (addr_i[1:0] == 2'b00) ? 4'b0011 :
                       (addr_i[1:0] == 2'b10) ? 4'b1100 : 4'b0000;

    assign half_misaligned = addr_i[0];
    assign word_misaligned = (addr_i[1:0] != 2'b00);

    always_comb begin
        dmem_sel_o   = '0;
        dmem_we_o    = 1'b0;
        dmem_wdata_o = '0;
        adel_o       = 1'b0;
        ades_o       = 1'b0;
        case (mem_op_i)
            MEM_LB, MEM_LBU: dmem_sel_o = byte_lane;
            MEM_LH, MEM_LHU: begin
                dmem_sel_o = half_lane;
                adel_o     = half_misaligned;
            end
            MEM_LW: begin
                dmem_sel_o = 4'b1111;
                adel_o     = word_misaligned;
            end
            MEM_SB: begin
                dmem_sel_o   = byte_lane;
                dmem_we_o    = 1'b1;
                dmem_wdata_o = {4{ops.rt_value[7:0]}};
            end
            MEM_SH: begin
                dmem_sel_o   = half_lane;
                dmem_we_o    = 1'b1;
                dmem_wdata_o = {2{ops.rt_value[15:0]}};
                ades_o       = half_misaligned;
            end
            MEM_SW: begin
                dmem_sel_o   = 4'b1111;
                dmem_we_o    = 1'b1;
                dmem_wdata_o = ops.rt_value;
                ades_o       = word_misaligned;
            end
            default: dmem_sel_o = '0;
        endcase
    end

    assign any_exc = ov_exc_i || adel_o || ades_o;

    // no memory traffic after an exception until the flush arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            store_block <= 1'b0;
        end else if (flush_i) begin
            store_block <= 1'b0;
        end else if (any_exc) begin
            store_block <= 1'b1;
        end
    end

    assign dmem_en_o   = (mem_op_i != MEM_NONE) && !any_exc && !store_block;
    assign dmem_addr_o = addr_i;

endmodule

//--- design/ex_operand_if.sv
`timescale 1ns/1ps

interface ex_operand_if import ex_pkg::*; ();

    // register operands after forwarding
    word_t rs_value;
    word_t rt_value;

    // chosen alu sources
    word_t src1;
    word_t src2;

    modport src (
        output rs_value, rt_value, src1, src2
    );

    modport alu (
        input src1, src2
    );

    modport branch (
        input rs_value, rt_value
    );

    modport mem (
        input rt_value
    );

endinterface

//--- design/ex_operand_sel.sv
`timescale 1ns/1ps

module ex_operand_sel import ex_pkg::*; (
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  src1_sel_e src1_sel_i,
    input  src2_sel_e src2_sel_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  logic      rs_fwd_i,
    input  logic      rt_fwd_i,
    input  word_t     rs_fwd_data_i,
    input  word_t     rt_fwd_data_i,
    ex_operand_if.src ops
);

    word_t rs_value;
    word_t rt_value;
    word_t imm_sign;
    word_t imm_zero;
    word_t shamt;

    // bypass overrides
    assign rs_value = rs_fwd_i ? rs_fwd_data_i : rs_data_i;
    assign rt_value = rt_fwd_i ? rt_fwd_data_i : rt_data_i;

    assign imm_sign = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zero = {16'b0, inst_i[15:0]};
    assign shamt    = {27'b0, inst_i[10:6]};

    always_comb begin
        case (src1_sel_i)
            SRC1_PC:    ops.src1 = pc_i;
            SRC1_SHAMT: ops.src1 = shamt;
            default:    ops.src1 = rs_value;
        endcase
    end

    always_comb begin
        case (src2_sel_i)
            SRC2_IMM_SIGN:    ops.src2 = imm_sign;
            SRC2_LINK_OFFSET: ops.src2 = LINK_OFFSET;
            SRC2_IMM_ZERO:    ops.src2 = imm_zero;
            default:          ops.src2 = rt_value;
        endcase
    end

    assign ops.rs_value = rs_value;
    assign ops.rt_value = rt_value;

endmodule

//--- design/ex_pkg.sv
package ex_pkg;

    // widths fixed by the ISA
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_LANES = WORD_W / 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [BYTE_LANES-1:0] byte_sel_t;

    // pc + 8 for jal/jalr link values
    localparam word_t LINK_OFFSET = 32'd8;
    localparam word_t INST_STEP   = 32'd4;

    // add and sub trap on signed overflow
    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ,
        BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J,
        BR_JAL, BR_JR, BR_JALR
    } br_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU,
        MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {SRC1_RS, SRC1_PC, SRC1_SHAMT} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RT, SRC2_IMM_SIGN, SRC2_LINK_OFFSET, SRC2_IMM_ZERO} src2_sel_e;

    // all zeros is a bubble
    typedef struct packed {
        word_t     pc;
        word_t     inst;
        alu_op_e   alu_op;
        br_op_e    br_op;
        mem_op_e   mem_op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rs_data;
        word_t     rt_data;
    } ex_ctrl_t;

endpackage

//--- design/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush_i,
    input  logic      stall_i,
    input  logic      mem_stall_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  alu_op_e   alu_op_i,
    input  br_op_e    br_op_i,
    input  mem_op_e   mem_op_i,
    input  src1_sel_e src1_sel_i,
    input  src2_sel_e src2_sel_i,
    input  logic      rf_we_i,
    input  reg_addr_t rf_waddr_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  logic      rs_fwd_i,
    input  word_t     rs_fwd_data_i,
    input  logic      rt_fwd_i,
    input  word_t     rt_fwd_data_i,
    input  logic      bp_taken_i,
    input  word_t     bp_target_i,
    output word_t     pc_o,
    output word_t     ex_result_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output logic      br_redirect_o,
    output word_t     br_target_o,
    output logic      dmem_en_o,
    output logic      dmem_we_o,
    output byte_sel_t dmem_sel_o,
    output word_t     dmem_addr_o,
    output word_t     dmem_wdata_o,
    output logic      ov_exc_o,
    output logic      adel_o,
    output logic      ades_o,
    output word_t     bad_vaddr_o
);

    ex_ctrl_t ctrl_in;
    ex_ctrl_t ctrl;
    word_t    alu_result;

    ex_operand_if ops_if ();

    assign ctrl_in = '{
        pc:       pc_i,
        inst:     inst_i,
        alu_op:   alu_op_i,
        br_op:    br_op_i,
        mem_op:   mem_op_i,
        src1_sel: src1_sel_i,
        src2_sel: src2_sel_i,
        rf_we:    rf_we_i,
        rf_waddr: rf_waddr_i,
        rs_data:  rs_data_i,
        rt_data:  rt_data_i
    };

    ex_stage_reg u_stage_reg (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .stall_i     (stall_i),
        .mem_stall_i (mem_stall_i),
        .ctrl_i      (ctrl_in),
        .ctrl_o      (ctrl)
    );

    ex_operand_sel u_operand_sel (
        .pc_i          (ctrl.pc),
        .inst_i        (ctrl.inst),
        .src1_sel_i    (ctrl.src1_sel),
        .src2_sel_i    (ctrl.src2_sel),
        .rs_data_i     (ctrl.rs_data),
        .rt_data_i     (ctrl.rt_data),
        .rs_fwd_i      (rs_fwd_i),
        .rt_fwd_i      (rt_fwd_i),
        .rs_fwd_data_i (rs_fwd_data_i),
        .rt_fwd_data_i (rt_fwd_data_i),
        .ops           (ops_if)
    );

    ex_alu u_alu (
        .alu_op_i (ctrl.alu_op),
        .ops      (ops_if),
        .result_o (alu_result),
        .ov_exc_o (ov_exc_o)
    );

    ex_branch_check u_branch_check (
        .br_op_i     (ctrl.br_op),
        .pc_i        (ctrl.pc),
        .inst_i      (ctrl.inst),
        .ops         (ops_if),
        .bp_taken_i  (bp_taken_i),
        .bp_target_i (bp_target_i),
        .redirect_o  (br_redirect_o),
        .target_o    (br_target_o)
    );

    ex_mem_access u_mem_access (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .mem_op_i     (ctrl.mem_op),
        .addr_i       (alu_result),
        .ov_exc_i     (ov_exc_o),
        .ops          (ops_if),
        .dmem_en_o    (dmem_en_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_sel_o   (dmem_sel_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .adel_o       (adel_o),
        .ades_o       (ades_o)
    );

    assign pc_o        = ctrl.pc;
    assign rf_we_o     = ctrl.rf_we;
    assign rf_waddr_o  = ctrl.rf_waddr;
    assign ex_result_o = alu_result;
    // the faulting address is always the computed one here
    assign bad_vaddr_o = alu_result;

endmodule

//--- design/ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg import ex_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush_i,
    input  logic     stall_i,
    input  logic     mem_stall_i,
    input  ex_ctrl_t ctrl_i,
    output ex_ctrl_t ctrl_o
);

    ex_ctrl_t ctrl_q;

    logic load_bubble;
    logic load_new;

    // ex stalled while mem moves on gets a bubble
    assign load_bubble = flush_i || (stall_i && !mem_stall_i);
    assign load_new    = !stall_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= '0;
        end else if (load_bubble) begin
            ctrl_q <= '0;
        end else if (load_new) begin
            ctrl_q <= ctrl_i;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

//--- ex_stage.f
design/ex_pkg.sv
design/ex_operand_if.sv
design/ex_stage_reg.sv
design/ex_operand_sel.sv
design/ex_alu.sv
design/ex_branch_check.sv
design/ex_mem_access.sv
design/ex_stage.sv
tb/ex_stage_properties.sv
tb/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f ex_stage.f --top-module ex_stage_tb -o ex_stage_sim \
    && ./obj_dir/ex_stage_sim | tee sim.log
grep -qs "^TEST PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb/ex_stage_properties.sv
`timescale 1ns/1ps

module ex_stage_properties import ex_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      flush_i,
    input logic      rf_we_o,
    input logic      br_redirect_o,
    input word_t     br_target_o,
    input logic      dmem_en_o,
    input byte_sel_t dmem_sel_o,
    input logic      ov_exc_o,
    input logic      adel_o,
    input logic      ades_o
);

    a_no_access_on_exc: assert property (@(posedge clk) disable iff (rst)
        dmem_en_o |-> !(ov_exc_o || adel_o || ades_o))
        else $error("memory access enabled together with an exception");

    a_access_has_lanes: assert property (@(posedge clk) disable iff (rst)
        dmem_en_o |-> (dmem_sel_o != '0))
        else $error("memory access enabled with no byte lanes");

    // flush turns the next instruction into a bubble
    a_flush_kills_write: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !rf_we_o)
        else $error("register write still enabled after a flush");

    a_target_idle: assert property (@(posedge clk) disable iff (rst)
        !br_redirect_o |-> (br_target_o == '0))
        else $error("branch target nonzero without a redirect");

endmodule

bind ex_stage ex_stage_properties u_properties (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .rf_we_o       (rf_we_o),
    .br_redirect_o (br_redirect_o),
    .br_target_o   (br_target_o),
    .dmem_en_o     (dmem_en_o),
    .dmem_sel_o    (dmem_sel_o),
    .ov_exc_o      (ov_exc_o),
    .adel_o        (adel_o),
    .ades_o        (ades_o)
);

//--- tb/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_TESTS     = 3000;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + NUM_TESTS + 20) * CLK_PERIOD;

    logic      clk;
    logic      rst;
    logic      flush_i;
    logic      stall_i;
    logic      mem_stall_i;
    word_t     pc_i;
    word_t     inst_i;
    alu_op_e   alu_op_i;
    br_op_e    br_op_i;
    mem_op_e   mem_op_i;
    src1_sel_e src1_sel_i;
    src2_sel_e src2_sel_i;
    logic      rf_we_i;
    reg_addr_t rf_waddr_i;
    word_t     rs_data_i;
    word_t     rt_data_i;
    logic      rs_fwd_i;
    word_t     rs_fwd_data_i;
    logic      rt_fwd_i;
    word_t     rt_fwd_data_i;
    logic      bp_taken_i;
    word_t     bp_target_i;
    word_t     pc_o;
    word_t     ex_result_o;
    logic      rf_we_o;
    reg_addr_t rf_waddr_o;
    logic      br_redirect_o;
    word_t     br_target_o;
    logic      dmem_en_o;
    logic      dmem_we_o;
    byte_sel_t dmem_sel_o;
    word_t     dmem_addr_o;
    word_t     dmem_wdata_o;
    logic      ov_exc_o;
    logic      adel_o;
    logic      ades_o;
    word_t     bad_vaddr_o;

    integer   seed;
    int       cycle;
    ex_ctrl_t drv;
    // reference copy of the stage register and the store block
    ex_ctrl_t m_reg;
    logic     m_block;

    word_t     e_rs, e_rt, e_src1, e_src2, e_result, e_actual, e_target, e_wdata;
    logic      e_ov, e_taken, e_redirect, e_en, e_we, e_adel, e_ades;
    byte_sel_t e_sel;
    int        seen_ov, seen_redirect, seen_en, seen_align;

    ex_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before all cycles were checked");
        $display("TEST FAIL");
        $fatal(1, "simulation timed out");
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // small values half of the time so both aligned and unaligned addresses show up
    function automatic word_t rand_data();
        if (rand_below(2) == 0)
            return word_t'(rand_below(64));
        return word_t'($random(seed));
    endfunction

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sel(input string name, input byte_sel_t got, input byte_sel_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compute_expected();
        word_t       imm_se;
        word_t       pc4;
        logic [4:0]  sh;
        logic [1:0]  off;
        byte_sel_t   byte_lanes;
        byte_sel_t   half_lanes;
        longint      wide;
        e_rs = rs_fwd_i ? rs_fwd_data_i : m_reg.rs_data;
        e_rt = rt_fwd_i ? rt_fwd_data_i : m_reg.rt_data;
        imm_se = {{16{m_reg.inst[15]}}, m_reg.inst[15:0]};
        case (m_reg.src1_sel)
            SRC1_PC:    e_src1 = m_reg.pc;
            SRC1_SHAMT: e_src1 = {27'b0, m_reg.inst[10:6]};
            default:    e_src1 = e_rs;
        endcase
        case (m_reg.src2_sel)
            SRC2_IMM_SIGN:    e_src2 = imm_se;
            SRC2_LINK_OFFSET: e_src2 = 32'd8;
            SRC2_IMM_ZERO:    e_src2 = {16'b0, m_reg.inst[15:0]};
            default:          e_src2 = e_rt;
        endcase
        sh = e_src1[4:0];
        case (m_reg.alu_op)
            ALU_ADD, ALU_ADDU: e_result = e_src1 + e_src2;
            ALU_SUB, ALU_SUBU: e_result = e_src1 - e_src2;
            ALU_SLT:  e_result = ($signed(e_src1) < $signed(e_src2)) ? 32'd1 : 32'd0;
            ALU_SLTU: e_result = (e_src1 < e_src2) ? 32'd1 : 32'd0;
            ALU_AND:  e_result = e_src1 & e_src2;
            ALU_OR:   e_result = e_src1 | e_src2;
            ALU_XOR:  e_result = e_src1 ^ e_src2;
            ALU_NOR:  e_result = ~(e_src1 | e_src2);
            ALU_SLL:  e_result = e_src2 << sh;
            ALU_SRL:  e_result = e_src2 >> sh;
            ALU_SRA:  e_result = (e_src2 >> sh) | (e_src2[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            default:  e_result = {e_src2[15:0], 16'h0};
        endcase
        // signed overflow from the exact 64-bit sum or difference
        if (m_reg.alu_op == ALU_SUB)
            wide = longint'($signed(e_src1)) - longint'($signed(e_src2));
        else
            wide = longint'($signed(e_src1)) + longint'($signed(e_src2));
        e_ov = (m_reg.alu_op inside {ALU_ADD, ALU_SUB}) &&
               (wide > 64'sd2147483647 || wide < -64'sd2147483648);

        pc4 = m_reg.pc + 32'd4;
        e_actual = pc4 + (imm_se << 2);
        case (m_reg.br_op)
            BR_BEQ:  e_taken = (e_rs == e_rt);
            BR_BNE:  e_taken = (e_rs != e_rt);
            BR_BGEZ: e_taken = ($signed(e_rs) >= 0);
            BR_BGTZ: e_taken = ($signed(e_rs) > 0);
            BR_BLEZ: e_taken = ($signed(e_rs) <= 0);
            BR_BLTZ: e_taken = ($signed(e_rs) < 0);
            BR_J, BR_JAL: begin
                e_taken  = 1'b1;
                e_actual = {pc4[31:28], m_reg.inst[25:0], 2'b00};
            end
            BR_JR, BR_JALR: begin
                e_taken  = 1'b1;
                e_actual = e_rs;
            end
            default: e_taken = 1'b0;
        endcase
        if (e_taken && (!bp_taken_i || bp_target_i != e_actual)) begin
            e_redirect = 1'b1;
            e_target   = e_actual;
        end else if (bp_taken_i && !e_taken) begin
            e_redirect = 1'b1;
            e_target   = m_reg.pc + 32'd8;
        end else begin
            e_redirect = 1'b0;
            e_target   = '0;
        end

        off = e_result[1:0];
        byte_lanes = 4'b0001 << off;
        half_lanes = (off == 2'd0) ? 4'b0011 : (off == 2'd2) ? 4'b1100 : 4'b0000;
        e_sel = '0;
        e_we = 1'b0;
        e_wdata = '0;
        e_adel = 1'b0;
        e_ades = 1'b0;
        case (m_reg.mem_op)
            MEM_LB, MEM_LBU: e_sel = byte_lanes;
            MEM_LH, MEM_LHU: begin
                e_sel  = half_lanes;
                e_adel = e_result[0];
            end
            MEM_LW: begin
                e_sel  = 4'b1111;
                e_adel = (off != 2'd0);
            end
            MEM_SB: begin
                e_sel   = byte_lanes;
                e_we    = 1'b1;
                e_wdata = {4{e_rt[7:0]}};
            end
            MEM_SH: begin
                e_sel   = half_lanes;
                e_we    = 1'b1;
                e_wdata = {2{e_rt[15:0]}};
                e_ades  = e_result[0];
            end
            MEM_SW: begin
                e_sel   = 4'b1111;
                e_we    = 1'b1;
                e_wdata = e_rt;
                e_ades  = (off != 2'd0);
            end
            default: e_sel = '0;
        endcase
        e_en = (m_reg.mem_op != MEM_NONE) && !(e_ov || e_adel || e_ades) && !m_block;
    endtask

    task automatic drive_inputs();
        drv.pc       = word_t'($random(seed)) & 32'hFFFF_FFFC;
        drv.inst     = word_t'($random(seed));
        if (rand_below(2) == 0)
            drv.inst[15:0] = 16'(rand_below(16));
        drv.alu_op   = alu_op_e'(4'(rand_below(14)));
        drv.br_op    = br_op_e'(4'(rand_below(11)));
        drv.mem_op   = mem_op_e'(4'(rand_below(9)));
        drv.src1_sel = src1_sel_e'(2'(rand_below(3)));
        drv.src2_sel = src2_sel_e'(2'(rand_below(4)));
        drv.rf_we    = (rand_below(2) == 1);
        drv.rf_waddr = reg_addr_t'(rand_below(32));
        drv.rs_data  = rand_data();
        drv.rt_data  = rand_data();
        pc_i          = drv.pc;
        inst_i        = drv.inst;
        alu_op_i      = drv.alu_op;
        br_op_i       = drv.br_op;
        mem_op_i      = drv.mem_op;
        src1_sel_i    = drv.src1_sel;
        src2_sel_i    = drv.src2_sel;
        rf_we_i       = drv.rf_we;
        rf_waddr_i    = drv.rf_waddr;
        rs_data_i     = drv.rs_data;
        rt_data_i     = drv.rt_data;
        flush_i       = (rand_below(16) == 0);
        stall_i       = (rand_below(8) == 0);
        mem_stall_i   = (rand_below(2) == 1);
        rs_fwd_i      = (rand_below(4) == 0);
        rt_fwd_i      = (rand_below(4) == 0);
        rs_fwd_data_i = rand_data();
        rt_fwd_data_i = rand_data();
        // half of the predictions hit the real target of the instruction in the register
        compute_expected();
        bp_taken_i  = (rand_below(2) == 1);
        bp_target_i = (rand_below(2) == 0) ? e_actual : word_t'($random(seed)) & 32'hFFFF_FFFC;
    endtask

    task automatic check_outputs();
        check_word("pc_o", pc_o, m_reg.pc);
        check_word("ex_result_o", ex_result_o, e_result);
        check_flag("rf_we_o", rf_we_o, m_reg.rf_we);
        check_reg_addr("rf_waddr_o", rf_waddr_o, m_reg.rf_waddr);
        check_flag("ov_exc_o", ov_exc_o, e_ov);
        check_flag("br_redirect_o", br_redirect_o, e_redirect);
        check_word("br_target_o", br_target_o, e_target);
        check_flag("dmem_en_o", dmem_en_o, e_en);
        check_flag("dmem_we_o", dmem_we_o, e_we);
        check_sel("dmem_sel_o", dmem_sel_o, e_sel);
        check_word("dmem_addr_o", dmem_addr_o, e_result);
        if (e_we)
            check_word("dmem_wdata_o", dmem_wdata_o, e_wdata);
        check_flag("adel_o", adel_o, e_adel);
        check_flag("ades_o", ades_o, e_ades);
        check_word("bad_vaddr_o", bad_vaddr_o, e_result);
        seen_ov       += int'(e_ov);
        seen_redirect += int'(e_redirect);
        seen_en       += int'(e_en);
        seen_align    += int'(e_adel || e_ades);
    endtask

    // same priority as the stage register, flush before bubble before load before hold
    task automatic update_model();
        if (flush_i)
            m_block = 1'b0;
        else if (e_ov || e_adel || e_ades)
            m_block = 1'b1;
        if (flush_i || (stall_i && !mem_stall_i))
            m_reg = '0;
        else if (!stall_i)
            m_reg = drv;
    endtask

    initial begin
        seed = 92580;
        rst = 1'b1;
        flush_i       = 1'b0;
        stall_i       = 1'b0;
        mem_stall_i   = 1'b0;
        rf_we_i       = 1'b0;
        rs_fwd_i      = 1'b0;
        rt_fwd_i      = 1'b0;
        bp_taken_i    = 1'b0;
        pc_i          = '0;
        inst_i        = '0;
        rs_data_i     = '0;
        rt_data_i     = '0;
        rs_fwd_data_i = '0;
        rt_fwd_data_i = '0;
        bp_target_i   = '0;
        alu_op_i   = ALU_ADD;
        br_op_i    = BR_NONE;
        mem_op_i   = MEM_NONE;
        src1_sel_i = SRC1_RS;
        src2_sel_i = SRC2_RT;
        rf_waddr_i = '0;
        drv        = '0;
        m_reg      = '0;
        m_block    = 1'b0;
        seen_ov       = 0;
        seen_redirect = 0;
        seen_en       = 0;
        seen_align    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (cycle = 0; cycle < NUM_TESTS; cycle++) begin
            drive_inputs();
            #2;
            compute_expected();
            check_outputs();
            update_model();
            @(posedge clk);
            #1;
        end
        if (seen_ov == 0 || seen_redirect == 0 || seen_en == 0 || seen_align == 0) begin
            $display("random stimulus missed overflow, redirect, memory access or alignment cases");
            $display("TEST FAIL");
            $fatal(1, "incomplete stimulus");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
